// ==== files.f ====
common/id_pkg.sv
design/inst_apb_port.sv
design/inst_queue.sv
id_stage/decoder.sv
id_stage/id_stage.sv
design/front_top.sv
testbench/id_checker.sv
testbench/tb_front.sv

// ==== Bender.yml ====
package:
  name: id_front

sources:
  - files:
      - common/id_pkg.sv
      - design/inst_apb_port.sv
      - design/inst_queue.sv
      - id_stage/decoder.sv
      - id_stage/id_stage.sv
      - design/front_top.sv
  - target: test
    files:
      - testbench/id_checker.sv
      - testbench/tb_front.sv

// ==== testbench/tb_front.sv ====
`timescale 1ns/10ps

module tb_front;
  import id_pkg::*;

  localparam int n_trans      = 121; // writes and reads over all tests
  localparam int reset_cycles = 8;

  logic        clock;
  logic        arst_n;
  logic        rename_ready;
  logic        end_of_test;
  logic        rr_random;   // rename_ready drawn every cycle
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        dec_valid;
  dec_pkt_t    dec_pkt;
  int          pending;
  int          mismatch_errs;
  int          stray_errs;
  int          lost_errs;
  int          apb_errs;
  int          total;
  string       test_name;
  logic [15:0] lfsr_q;
  logic [12:0] int_ops [17]; // {opcode, function}
  opcode_t     mb_ops [12];
  logic [31:0] r;
  inst_t       w;
  logic        err;

  front_top DUT (
    .clock        (clock),
    .arst_n       (arst_n),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .dec_valid    (dec_valid),
    .dec_pkt      (dec_pkt),
    .rename_ready (rename_ready)
  );

  id_checker u_checker (
    .clock         (clock),
    .arst_n        (arst_n),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .dec_valid     (dec_valid),
    .dec_pkt       (dec_pkt),
    .rename_ready  (rename_ready),
    .end_of_test   (end_of_test),
    .pending       (pending),
    .mismatch_errs (mismatch_errs),
    .stray_errs    (stray_errs),
    .lost_errs     (lost_errs)
  );

  initial
    clock = 1'b0;
  always #4 clock = ~clock; // 8 ns period

  //////////////////////////////////////////////////
  // random source and apb driver
  //////////////////////////////////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v      = {v[30:0], lfsr_q[0]}; // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic pace_ready();
    logic [31:0] b;
    if (rr_random)
    begin
      draw_bits(1, b);
      rename_ready = b[0];
    end
  endtask

  // every access phase completes without wait states
  task automatic check_pready();
    if (apb_rsp.pready !== 1'b1)
    begin
      apb_errs++;
      $display("CHECK FAILED %s: pready expected 1 actual %b", test_name, apb_rsp.pready);
    end
  endtask

  // called 1 ns after an edge, returns 1 ns after the access edge
  task automatic apb_write(input apb_addr_t a, input inst_t d, output logic e);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: a, pwdata: d};
    pace_ready();
    @(posedge clock);
    #1 apb_req.penable = 1'b1;
    pace_ready();
    @(negedge clock);
    e = apb_rsp.pslverr;
    check_pready();
    @(posedge clock);
    #1 apb_req = '0;
  endtask

  task automatic apb_read(input apb_addr_t a, output logic [31:0] d);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: a, pwdata: '0};
    @(posedge clock);
    #1 apb_req.penable = 1'b1;
    @(negedge clock);
    d = apb_rsp.prdata;
    check_pready();
    @(posedge clock);
    #1 apb_req = '0;
  endtask

  task automatic put_word(input inst_t word, input logic exp_err);
    logic e;
    apb_write(addr_inst, word, e);
    if (e !== exp_err)
    begin
      apb_errs++;
      $display("CHECK FAILED %s: pslverr expected %0b actual %0b", test_name, exp_err, e);
    end
  endtask

  task automatic check_count(input int exp_cnt);
    logic [31:0] d;
    apb_read(addr_stat, d);
    if (d !== exp_cnt)
    begin
      apb_errs++;
      $display("CHECK FAILED %s: queue count expected %0d actual %0d", test_name, exp_cnt, d);
    end
  endtask

  // random register fields and literal flag around a fixed op and function
  task automatic make_int(input opcode_t op, input func_t fn, output inst_t word);
    logic [31:0] v;
    draw_bits(19, v);
    word = {op, v[18:5], fn, v[4:0]};
  endtask

  task automatic rand_int(output inst_t word);
    logic [31:0] v;
    logic [12:0] sel;
    draw_bits(5, v);
    sel = int_ops[v % 17];
    make_int(sel[12:7], sel[6:0], word);
  endtask

  // pending is read 1 ns after each edge, once the checker has updated it
  task automatic wait_drain();
    while (pending != 0)
    begin
      @(posedge clock);
      #1;
    end
    @(posedge clock);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name           = name;
    u_checker.test_name = name;
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  initial
  begin
    apb_req      = '0;
    rename_ready = 1'b1;
    arst_n       = 1'b0;
    end_of_test  = 1'b0;
    rr_random    = 1'b0;
    apb_errs     = 0;
    lfsr_q       = 16'd74;
    int_ops = '{{inta_grp, addq_fn}, {inta_grp, subq_fn}, {inta_grp, cmpeq_fn},
                {inta_grp, cmpult_fn}, {inta_grp, cmple_fn}, {inta_grp, cmplt_fn},
                {inta_grp, cmpule_fn}, {intl_grp, and_fn}, {intl_grp, bic_fn},
                {intl_grp, bis_fn}, {intl_grp, ornot_fn}, {intl_grp, xor_fn},
                {intl_grp, eqv_fn}, {ints_grp, srl_fn}, {ints_grp, sll_fn},
                {ints_grp, sra_fn}, {intm_grp, mulq_fn}};
    mb_ops  = '{lda_inst, ldq_inst, ldq_l_inst, stq_inst, stq_c_inst, jsr_grp,
                br_inst, bsr_inst, 6'h39, 6'h3e, fbeq_inst, fbgt_inst};
    repeat (reset_cycles) @(posedge clock);
    #1 arst_n = 1'b1;
    @(posedge clock);
    #1;

    start_test("int_ops");
    repeat (40)
    begin
      rand_int(w);
      put_word(w, 1'b0);
    end
    wait_drain();

    start_test("mem_branch");
    repeat (2)
      foreach (mb_ops[i])
      begin
        draw_bits(26, r);
        put_word({mb_ops[i], r[25:0]}, 1'b0);
      end
    wait_drain();

    start_test("back_pressure");
    rename_ready = 1'b0;
    for (int i = 0; i < 6; i++)
    begin
      rand_int(w);
      put_word(w, i == 5); // register and four entries take the first five
    end
    check_count(4);
    rename_ready = 1'b1;
    wait_drain();

    start_test("random_ready");
    rr_random = 1'b1;
    repeat (30)
    begin
      rand_int(w);
      apb_write(addr_inst, w, err); // drops on full are legal here
    end
    rr_random    = 1'b0;
    rename_ready = 1'b1;
    wait_drain();

    start_test("illegal_whami");
    make_int(inta_grp, 7'h01, w);
    put_word(w, 1'b0);
    make_int(intl_grp, 7'h7f, w);
    put_word(w, 1'b0);
    make_int(ints_grp, 7'h00, w);
    put_word(w, 1'b0);
    make_int(intm_grp, 7'h21, w);
    put_word(w, 1'b0);
    make_int(6'h16, addq_fn, w); // fp operate
    put_word(w, 1'b0);
    draw_bits(26, r);
    put_word({6'h1c, r[25:0]}, 1'b0); // ftpi
    put_word({6'h18, r[25:0]}, 1'b0); // misc
    put_word({pal_inst, 26'h0}, 1'b0);
    put_word({pal_inst, pal_whami}, 1'b0);
    wait_drain();

    start_test("halt");
    put_word({pal_inst, pal_halt}, 1'b0);
    wait_drain();
    for (int i = 1; i <= 5; i++)
    begin
      rand_int(w);
      put_word(w, i == 5);
      check_count(i < 4 ? i : 4); // nothing pops any more
    end
    repeat (10) @(posedge clock);

    end_of_test = 1'b1;
    #1;
    total = mismatch_errs + stray_errs + lost_errs + apb_errs;
    $display("errors: decode %0d, stray %0d, lost %0d, apb %0d",
             mismatch_errs, stray_errs, lost_errs, apb_errs);
    if (total == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog allows 20 cycles per transaction plus reset
  initial
  begin
    #((n_trans * 20 + reset_cycles) * 8);
    $display("ERROR: watchdog expired, tests did not finish in %0d cycles",
             n_trans * 20 + reset_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== testbench/id_checker.sv ====
`timescale 1ns/10ps

module id_checker (
  input  logic             clock,
  input  logic             arst_n,
  input  id_pkg::apb_req_t apb_req,
  input  id_pkg::apb_rsp_t apb_rsp,
  input  logic             dec_valid,
  input  id_pkg::dec_pkt_t dec_pkt,
  input  logic             rename_ready,
  input  logic             end_of_test,   // rises once, after the last test
  output int               pending,       // accepted words not yet taken
  output int               mismatch_errs,
  output int               stray_errs,
  output int               lost_errs
);
  import id_pkg::*;

  string    test_name;
  inst_t    exp_words [$];  // accepted words, in push order
  string    exp_tests [$];
  logic     halt_seen;      // words behind a halt never leave the queue
  inst_t    word;
  string    name;
  dec_pkt_t exp_pkt;
  dec_pkt_t acc_pkt;

  //////////////////////////////////////////////////
  // reference decode, straight from the alpha encoding
  //////////////////////////////////////////////////
  function automatic dec_pkt_t ref_decode(input inst_t w);
    dec_pkt_t p;
    opcode_t  op;
    op          = w[31:26];
    p           = '0;
    p.opa_sel   = opa_is_rega;
    p.opb_sel   = opb_is_regb;
    p.alu_func  = alu_addq;
    p.fu_name   = fu_alu;
    p.rdest_idx = zero_reg;
    if (op == pal_inst)
    begin
      p.halt    = (w[25:0] == pal_halt);
      p.cpuid   = (w[25:0] == pal_whami);
      p.illegal = ~(p.halt | p.cpuid);
      if (p.cpuid)
        p.rdest_idx = w[25:21];
    end
    else if (op[5:3] == 3'b010) // operate format, 0x10..0x17
    begin
      p.opb_sel   = w[12] ? opb_is_alu_imm : opb_is_regb;
      p.rdest_idx = w[4:0];   // rc
      p.fu_name   = (op == intm_grp) ? fu_mult : fu_alu;
      case ({op, w[11:5]})
        {inta_grp, addq_fn}:   p.alu_func = alu_addq;
        {inta_grp, subq_fn}:   p.alu_func = alu_subq;
        {inta_grp, cmpeq_fn}:  p.alu_func = alu_cmpeq;
        {inta_grp, cmpult_fn}: p.alu_func = alu_cmpult;
        {inta_grp, cmple_fn}:  p.alu_func = alu_cmple;
        {inta_grp, cmplt_fn}:  p.alu_func = alu_cmplt;
        {inta_grp, cmpule_fn}: p.alu_func = alu_cmpule;
        {intl_grp, and_fn}:    p.alu_func = alu_and;
        {intl_grp, bic_fn}:    p.alu_func = alu_bic;
        {intl_grp, bis_fn}:    p.alu_func = alu_bis;
        {intl_grp, ornot_fn}:  p.alu_func = alu_ornot;
        {intl_grp, xor_fn}:    p.alu_func = alu_xor;
        {intl_grp, eqv_fn}:    p.alu_func = alu_eqv;
        {ints_grp, srl_fn}:    p.alu_func = alu_srl;
        {ints_grp, sll_fn}:    p.alu_func = alu_sll;
        {ints_grp, sra_fn}:    p.alu_func = alu_sra;
        {intm_grp, mulq_fn}:   p.alu_func = alu_mulq;
        default:               p.illegal  = 1'b1;
      endcase
    end
    else if (op == jsr_grp)
    begin
      p.fu_name       = fu_br;
      p.opa_sel       = opa_is_not3;
      p.alu_func      = alu_and;
      p.uncond_branch = 1'b1;
      p.rdest_idx     = w[25:21]; // return address
    end
    else if (op[5:3] == 3'b001 || op[5:4] == 2'b10) // memory format
    begin
      p.opa_sel   = opa_is_mem_disp;
      p.fu_name   = fu_ld;
      p.rdest_idx = (op == stq_inst) ? zero_reg : w[25:21];
      p.rd_mem    = (op == ldq_inst) || (op == ldq_l_inst);
      p.ldl_mem   = (op == ldq_l_inst);
      p.wr_mem    = (op == stq_inst) || (op == stq_c_inst);
      p.stc_mem   = (op == stq_c_inst);
      p.illegal   = ~(p.rd_mem | p.wr_mem | (op == lda_inst));
    end
    else if (op[5:4] == 2'b11) // branch format
    begin
      p.opa_sel = opa_is_npc;
      p.opb_sel = opb_is_br_disp;
      if (op == br_inst || op == bsr_inst)
      begin
        p.uncond_branch = 1'b1;
        p.fu_name       = fu_br;
        p.rdest_idx     = w[25:21];
      end
      else if (op[5:3] == 3'b110)
        p.illegal = 1'b1; // 0x31..0x37 minus bsr are fp
      else
        p.cond_branch = 1'b1;
    end
    else
      p.illegal = 1'b1; // misc, ftpi and unused opcodes
    p.valid_inst = ~p.illegal;
    p.ra_idx     = (p.opa_sel == opa_is_rega) ? w[25:21] : zero_reg;
    p.rb_idx     = (p.opb_sel == opb_is_regb) ? w[20:16] : zero_reg;
    return p;
  endfunction

  initial
  begin
    test_name     = "none";
    halt_seen     = 1'b0;
    pending       = 0;
    mismatch_errs = 0;
    stray_errs    = 0;
    lost_errs     = 0;
  end

  always @(posedge clock)
  begin
    if (arst_n)
    begin
      // accepted push, access phase without pslverr
      if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
          apb_req.paddr == addr_inst && !apb_rsp.pslverr && !halt_seen)
      begin
        exp_words.push_back(apb_req.pwdata);
        exp_tests.push_back(test_name);
        acc_pkt   = ref_decode(apb_req.pwdata);
        halt_seen = acc_pkt.halt;
      end
      if (dec_valid && rename_ready) // packet taken by rename
      begin
        if (exp_words.size() == 0)
        begin
          stray_errs++;
          $display("ERROR: decode packet %h was taken with no instruction outstanding",
                   dec_pkt);
        end
        else
        begin
          word    = exp_words.pop_front();
          name    = exp_tests.pop_front();
          exp_pkt = ref_decode(word);
          if (dec_pkt !== exp_pkt)
          begin
            mismatch_errs++;
            $display("CHECK FAILED %s: inst %h expected %h actual %h",
                     name, word, exp_pkt, dec_pkt);
          end
        end
      end
      pending = exp_words.size();
    end
  end

  always @(posedge end_of_test)
  begin
    if (exp_words.size() != 0)
    begin
      lost_errs = exp_words.size();
      $display("ERROR: %0d accepted instructions never left decode, first one %h",
               exp_words.size(), exp_words[0]);
    end
  end

endmodule

// ==== design/front_top.sv ====
`timescale 1ns/10ps

module front_top (
  input  logic             clock,
  input  logic             arst_n,
  input  id_pkg::apb_req_t apb_req,
  output id_pkg::apb_rsp_t apb_rsp,
  output logic             dec_valid,
  output id_pkg::dec_pkt_t dec_pkt,
  input  logic             rename_ready
);
  import id_pkg::*;

  logic   push;
  inst_t  push_data;
  logic   full;
  q_cnt_t count;
  logic   pop;
  logic   head_valid;
  inst_t  head_inst;

  // host side, producer
  inst_apb_port u_apb_port (
    .clock     (clock),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .count     (count)
  );

  inst_queue u_queue (
    .clock      (clock),
    .arst_n     (arst_n),
    .push       (push),
    .push_data  (push_data),
    .full       (full),
    .count      (count),
    .pop        (pop),
    .head_valid (head_valid),
    .head_inst  (head_inst)
  );

  // consumer, feeds rename
  id_stage u_id_stage (
    .clock        (clock),
    .arst_n       (arst_n),
    .head_valid   (head_valid),
    .head_inst    (head_inst),
    .pop          (pop),
    .dec_valid    (dec_valid),
    .dec_pkt      (dec_pkt),
    .rename_ready (rename_ready)
  );

endmodule

// ==== id_stage/id_stage.sv ====
`timescale 1ns/10ps

module id_stage (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             head_valid,
  input  id_pkg::inst_t    head_inst,
  output logic             pop,
  output logic             dec_valid,
  output id_pkg::dec_pkt_t dec_pkt,
  input  logic             rename_ready
);
  import id_pkg::*;

  typedef enum logic {
    id_run,
    id_halted  // sticky until reset
  } id_state_e;

  id_state_e state_q;
  dec_pkt_t  dec_now;  // decode of the queue head
  logic      can_load;

  decoder u_decoder (
    .inst          (head_inst),
    .valid_inst_in (head_valid),
    .pkt           (dec_now)
  );

  // empty, or draining this cycle
  assign can_load = ~dec_valid | rename_ready;
  assign pop      = (state_q == id_run) & head_valid & can_load;

  //////////////////////////////////////////////////
  // output register and halt fsm
  //////////////////////////////////////////////////
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      dec_valid <= 1'b0;
      state_q   <= id_run;
    end
    else
    begin
      if (pop)
        dec_valid <= 1'b1;
      else if (rename_ready)
        dec_valid <= 1'b0; // taken, nothing behind it
      if (pop && dec_now.halt)
        state_q <= id_halted;
    end
  end

  always_ff @(posedge clock)
  begin
    if (pop)
      dec_pkt <= dec_now;
  end

  // rename stall holds the packet
  hold_on_stall: assert property (
    @(posedge clock) disable iff (!arst_n)
    dec_valid && !rename_ready |=> dec_valid && $stable(dec_pkt)
  );

endmodule

// ==== id_stage/decoder.sv ====
`timescale 1ns/10ps

module decoder (
  input  id_pkg::inst_t    inst,
  input  logic             valid_inst_in, // low gives a noop
  output id_pkg::dec_pkt_t pkt
);
  import id_pkg::*;

  opcode_t   op;
  func_t     fn;
  dest_sel_t dest_sel;

  assign op = inst[31:26];
  assign fn = inst[11:5];

  always_comb
  begin
    // noop defaults
    pkt           = '0;
    pkt.opa_sel   = opa_is_rega;
    pkt.opb_sel   = opb_is_regb;
    pkt.alu_func  = alu_addq;
    pkt.fu_name   = fu_alu;
    dest_sel      = dest_none;

    if (valid_inst_in)
    begin
      case (op[5:3]) // major group
        3'b000:
          if (op == pal_inst)
          begin
            if (inst[25:0] == pal_halt)
              pkt.halt = 1'b1;
            else if (inst[25:0] == pal_whami)
            begin
              pkt.cpuid = 1'b1;
              dest_sel  = dest_is_rega; // cpuid lands in ra
            end
            else
              pkt.illegal = 1'b1;
          end
          else
            pkt.illegal = 1'b1;

        //////////////////////////////////////////////////
        // integer operate
        //////////////////////////////////////////////////
        3'b010:
        begin
          pkt.opb_sel = inst[12] ? opb_is_alu_imm : opb_is_regb; // literal form
          dest_sel    = dest_is_regc;
          case (op)
            inta_grp:
              case (fn)
                addq_fn:   pkt.alu_func = alu_addq;
                subq_fn:   pkt.alu_func = alu_subq;
                cmpeq_fn:  pkt.alu_func = alu_cmpeq;
                cmpult_fn: pkt.alu_func = alu_cmpult;
                cmple_fn:  pkt.alu_func = alu_cmple;
                cmplt_fn:  pkt.alu_func = alu_cmplt;
                cmpule_fn: pkt.alu_func = alu_cmpule;
                default:   pkt.illegal  = 1'b1;
              endcase
            intl_grp:
              case (fn)
                and_fn:   pkt.alu_func = alu_and;
                bic_fn:   pkt.alu_func = alu_bic;
                bis_fn:   pkt.alu_func = alu_bis;
                ornot_fn: pkt.alu_func = alu_ornot;
                xor_fn:   pkt.alu_func = alu_xor;
                eqv_fn:   pkt.alu_func = alu_eqv;
                default:  pkt.illegal  = 1'b1;
              endcase
            ints_grp:
              case (fn)
                srl_fn:  pkt.alu_func = alu_srl;
                sll_fn:  pkt.alu_func = alu_sll;
                sra_fn:  pkt.alu_func = alu_sra;
                default: pkt.illegal  = 1'b1;
              endcase
            intm_grp:
            begin
              pkt.fu_name = fu_mult;
              if (fn == mulq_fn)
                pkt.alu_func = alu_mulq;
              else
                pkt.illegal = 1'b1;
            end
            default: pkt.illegal = 1'b1; // fp operate groups
          endcase
        end

        3'b011:
          if (op == jsr_grp)
          begin
            // jmp, jsr, ret, jsr_co all behave the same
            pkt.fu_name       = fu_br;
            pkt.opa_sel       = opa_is_not3;
            pkt.alu_func      = alu_and;  // word-align target
            dest_sel          = dest_is_rega;
            pkt.uncond_branch = 1'b1;
          end
          else
            pkt.illegal = 1'b1; // misc, ftpi

        //////////////////////////////////////////////////
        // memory
        //////////////////////////////////////////////////
        3'b001, 3'b100, 3'b101:
        begin
          pkt.opa_sel = opa_is_mem_disp;
          pkt.fu_name = fu_ld;
          dest_sel    = dest_is_rega;
          case (op)
            lda_inst:   ; // address only
            ldq_inst:   pkt.rd_mem = 1'b1;
            ldq_l_inst:
            begin
              pkt.rd_mem  = 1'b1;
              pkt.ldl_mem = 1'b1;
            end
            stq_inst:
            begin
              pkt.wr_mem = 1'b1;
              dest_sel   = dest_none;
            end
            stq_c_inst:
            begin
              pkt.wr_mem  = 1'b1;
              pkt.stc_mem = 1'b1; // success flag back into ra
            end
            default: pkt.illegal = 1'b1;
          endcase
        end

        default: // 3'b110, 3'b111 branches
        begin
          pkt.opa_sel = opa_is_npc;
          pkt.opb_sel = opb_is_br_disp;
          case (op)
            fbeq_inst, fblt_inst, fble_inst,
            fbne_inst, fbge_inst, fbgt_inst:
              pkt.illegal = 1'b1; // no fp
            br_inst, bsr_inst:
            begin
              dest_sel          = dest_is_rega; // link register
              pkt.uncond_branch = 1'b1;
              pkt.fu_name       = fu_br;
            end
            default: pkt.cond_branch = 1'b1;
          endcase
        end
      endcase
    end

    pkt.valid_inst = valid_inst_in & ~pkt.illegal; // halt still counts
    pkt.ra_idx     = (pkt.opa_sel == opa_is_rega) ? inst[25:21] : zero_reg;
    pkt.rb_idx     = (pkt.opb_sel == opb_is_regb) ? inst[20:16] : zero_reg;
    case (dest_sel)
      dest_is_regc: pkt.rdest_idx = inst[4:0];
      dest_is_rega: pkt.rdest_idx = inst[25:21];
      default:      pkt.rdest_idx = zero_reg;
    endcase
  end

endmodule

// ==== design/inst_queue.sv ====
`timescale 1ns/10ps

module inst_queue (
  input  logic           clock,
  input  logic           arst_n,
  input  logic           push,
  input  id_pkg::inst_t  push_data,
  output logic           full,
  output id_pkg::q_cnt_t count,
  input  logic           pop,
  output logic           head_valid,
  output id_pkg::inst_t  head_inst
);
  import id_pkg::*;

  inst_t  mem [q_depth]; // payload, no reset
  q_ptr_t wr_ptr;
  q_ptr_t rd_ptr;
  q_cnt_t cnt_q;
  logic   do_push;
  logic   do_pop;

  assign full       = (cnt_q == q_cnt_t'(q_depth));
  assign head_valid = (cnt_q != '0);
  assign head_inst  = mem[rd_ptr];
  assign count      = cnt_q;

  assign do_push = push & ~full;
  assign do_pop  = pop & head_valid;

  always_ff @(posedge clock)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // pointers wrap naturally at q_depth = 4
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 2'd1;
      if (do_pop)
        rd_ptr <= rd_ptr + 2'd1;
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 3'd1;
        2'b01:   cnt_q <= cnt_q - 3'd1;
        default: cnt_q <= cnt_q; // both or neither
      endcase
    end
  end

  //////////////////////////////////////////////////
  // producer and consumer must respect the flags
  //////////////////////////////////////////////////
  no_push_full: assert property (
    @(posedge clock) disable iff (!arst_n) full |-> !push
  );

  no_pop_empty: assert property (
    @(posedge clock) disable iff (!arst_n) !head_valid |-> !pop
  );

endmodule

// ==== design/inst_apb_port.sv ====
`timescale 1ns/10ps

module inst_apb_port (
  input  logic             clock,
  input  logic             arst_n,
  input  id_pkg::apb_req_t apb_req,
  output id_pkg::apb_rsp_t apb_rsp,
  output logic             push,
  output id_pkg::inst_t    push_data,
  input  logic             full,
  input  id_pkg::q_cnt_t   count
);
  import id_pkg::*;

  logic        setup_rd;  // setup phase of a read
  logic        access;    // access phase, always one cycle
  logic        acc_wr;
  logic        hit_inst;
  logic        hit_stat;
  logic        wr_err;
  logic [31:0] prdata_q;

  //////////////////////////////////////////////////
  // phase decode
  //////////////////////////////////////////////////
  assign access   = apb_req.psel & apb_req.penable;
  assign setup_rd = apb_req.psel & ~apb_req.penable & ~apb_req.pwrite;
  assign acc_wr   = access & apb_req.pwrite;
  assign hit_inst = (apb_req.paddr == addr_inst);
  assign hit_stat = (apb_req.paddr == addr_stat);

  // push on the edge closing the access phase, drop when full
  assign push      = acc_wr & hit_inst & ~full;
  assign push_data = apb_req.pwdata;
  assign wr_err    = acc_wr & (~hit_inst | full); // bad address or overflow

  // status sampled in setup, presented during access
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      prdata_q <= '0;
    else if (setup_rd && hit_stat)
      prdata_q <= {29'd0, count};
    else
      prdata_q <= '0; // idle bus reads back zero
  end

  always_comb
  begin
    apb_rsp         = '0;
    apb_rsp.prdata  = prdata_q;
    apb_rsp.pready  = 1'b1; // no wait states
    apb_rsp.pslverr = wr_err;
  end

  // access phase must follow a selected setup phase
  penable_needs_psel: assert property (
    @(posedge clock) disable iff (!arst_n)
    $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel)
  );

endmodule

// ==== common/id_pkg.sv ====
package id_pkg;

  //////////////////////////////////////////////////
  // widths that carry a meaning
  //////////////////////////////////////////////////
  typedef logic [31:0] inst_t;     // one instruction word
  typedef logic [4:0]  reg_idx_t;  // architectural register
  typedef logic [5:0]  opcode_t;   // major opcode, inst[31:26]
  typedef logic [6:0]  func_t;     // integer function, inst[11:5]
  typedef logic [25:0] pal_code_t; // pal function, inst[25:0]

  localparam reg_idx_t zero_reg = 5'd31; // r31 reads as zero

  // alu function codes
  typedef logic [4:0] alu_func_t;
  localparam alu_func_t alu_addq   = 5'd0;
  localparam alu_func_t alu_subq   = 5'd1;
  localparam alu_func_t alu_cmpeq  = 5'd2;
  localparam alu_func_t alu_cmpult = 5'd3;
  localparam alu_func_t alu_cmple  = 5'd4;
  localparam alu_func_t alu_cmplt  = 5'd5;
  localparam alu_func_t alu_cmpule = 5'd6;
  localparam alu_func_t alu_and    = 5'd7;
  localparam alu_func_t alu_bic    = 5'd8;
  localparam alu_func_t alu_bis    = 5'd9;
  localparam alu_func_t alu_ornot  = 5'd10;
  localparam alu_func_t alu_xor    = 5'd11;
  localparam alu_func_t alu_eqv    = 5'd12;
  localparam alu_func_t alu_srl    = 5'd13;
  localparam alu_func_t alu_sll    = 5'd14;
  localparam alu_func_t alu_sra    = 5'd15;
  localparam alu_func_t alu_mulq   = 5'd16;

  // operand muxes and destination choice
  typedef logic [1:0] opa_sel_t;
  localparam opa_sel_t opa_is_rega     = 2'd0;
  localparam opa_sel_t opa_is_npc      = 2'd1;
  localparam opa_sel_t opa_is_not3     = 2'd2;
  localparam opa_sel_t opa_is_mem_disp = 2'd3;

  typedef logic [1:0] opb_sel_t;
  localparam opb_sel_t opb_is_regb    = 2'd0;
  localparam opb_sel_t opb_is_alu_imm = 2'd1;
  localparam opb_sel_t opb_is_br_disp = 2'd2;

  typedef logic [1:0] dest_sel_t;
  localparam dest_sel_t dest_none    = 2'd0;
  localparam dest_sel_t dest_is_regc = 2'd1; // inst[4:0]
  localparam dest_sel_t dest_is_rega = 2'd2; // inst[25:21]

  typedef logic [1:0] fu_name_t;
  localparam fu_name_t fu_alu  = 2'd0;
  localparam fu_name_t fu_mult = 2'd1;
  localparam fu_name_t fu_ld   = 2'd2;
  localparam fu_name_t fu_br   = 2'd3;

  //////////////////////////////////////////////////
  // alpha opcodes and function fields
  //////////////////////////////////////////////////
  localparam opcode_t pal_inst   = 6'h00;
  localparam opcode_t lda_inst   = 6'h08;
  localparam opcode_t inta_grp   = 6'h10;
  localparam opcode_t intl_grp   = 6'h11;
  localparam opcode_t ints_grp   = 6'h12;
  localparam opcode_t intm_grp   = 6'h13;
  localparam opcode_t jsr_grp    = 6'h1a;
  localparam opcode_t ldq_inst   = 6'h29;
  localparam opcode_t ldq_l_inst = 6'h2b;
  localparam opcode_t stq_inst   = 6'h2d;
  localparam opcode_t stq_c_inst = 6'h2f;
  localparam opcode_t br_inst    = 6'h30;
  localparam opcode_t fbeq_inst  = 6'h31;
  localparam opcode_t fblt_inst  = 6'h32;
  localparam opcode_t fble_inst  = 6'h33;
  localparam opcode_t bsr_inst   = 6'h34;
  localparam opcode_t fbne_inst  = 6'h35;
  localparam opcode_t fbge_inst  = 6'h36;
  localparam opcode_t fbgt_inst  = 6'h37;

  localparam func_t addq_fn   = 7'h20; // inta
  localparam func_t subq_fn   = 7'h29;
  localparam func_t cmpeq_fn  = 7'h2d;
  localparam func_t cmpult_fn = 7'h1d;
  localparam func_t cmple_fn  = 7'h6d;
  localparam func_t cmplt_fn  = 7'h4d;
  localparam func_t cmpule_fn = 7'h3d;
  localparam func_t and_fn    = 7'h00; // intl
  localparam func_t bic_fn    = 7'h08;
  localparam func_t bis_fn    = 7'h20;
  localparam func_t ornot_fn  = 7'h28;
  localparam func_t xor_fn    = 7'h40;
  localparam func_t eqv_fn    = 7'h48;
  localparam func_t srl_fn    = 7'h34; // ints
  localparam func_t sll_fn    = 7'h39;
  localparam func_t sra_fn    = 7'h3c;
  localparam func_t mulq_fn   = 7'h20; // intm

  localparam pal_code_t pal_halt  = 26'h555;
  localparam pal_code_t pal_whami = 26'h03c;

  //////////////////////////////////////////////////
  // queue, apb and decode packet
  //////////////////////////////////////////////////
  localparam int q_depth = 4;
  typedef logic [2:0] q_cnt_t; // 0..q_depth
  typedef logic [1:0] q_ptr_t;

  typedef logic [3:0] apb_addr_t;
  localparam apb_addr_t addr_inst = 4'h0; // push register, write only
  localparam apb_addr_t addr_stat = 4'h4; // fill level, read only

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    inst_t     pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    opa_sel_t  opa_sel;
    opb_sel_t  opb_sel;
    alu_func_t alu_func;
    fu_name_t  fu_name;
    logic      rd_mem;
    logic      wr_mem;
    logic      ldl_mem;
    logic      stc_mem;
    logic      cond_branch;
    logic      uncond_branch;
    logic      halt;
    logic      cpuid;
    logic      illegal;
    logic      valid_inst;
    reg_idx_t  ra_idx;
    reg_idx_t  rb_idx;
    reg_idx_t  rdest_idx;
  } dec_pkt_t;

endpackage
